//--- hw/pcie_axil_pkg.sv
// PCIe to AXI-Lite bridge types

package pcie_axil_pkg;

    // ordering queue depth is 2**FIFO_ADDR_W
    localparam int FIFO_ADDR_W = 5;

    // unprivileged, non-secure, data access
    localparam logic [2:0] AXIL_PROT = 3'b010;

    typedef logic [31:0]  dw_t;
    typedef logic [127:0] tlp_hdr_t;
    typedef logic [63:0]  axil_addr_t;
    typedef logic [3:0]   strb_t;
    typedef logic [15:0]  req_id_t;
    typedef logic [9:0]   tag_t;
    typedef logic [6:0]   lower_addr_t;
    typedef logic [2:0]   byte_cnt_t;  // 1 to 4 bytes

    // fmt field of DW0
    typedef enum logic [2:0] {
        FMT_3DW      = 3'b000,
        FMT_4DW      = 3'b001,
        FMT_3DW_DATA = 3'b010,
        FMT_4DW_DATA = 3'b011,
        FMT_PREFIX   = 3'b100
    } tlp_fmt_e;

    typedef enum logic [2:0] {
        CPL_SC  = 3'b000,  // successful
        CPL_UR  = 3'b001,  // unsupported request
        CPL_CRS = 3'b010,  // config retry
        CPL_CA  = 3'b100   // completer abort
    } cpl_status_e;

    // what the completion stage waits for
    typedef enum logic [1:0] {
        OP_READ  = 2'd0,  // R data, then completion with data
        OP_WRITE = 2'd1,  // B response only
        OP_CPL   = 2'd2   // data-less completion right away
    } resp_op_e;

    // one pending response, in request order
    typedef struct packed {
        resp_op_e    op;
        cpl_status_e status;
        byte_cnt_t   byte_count;
        lower_addr_t lower_addr;
        req_id_t     requester_id;
        tag_t        tag;
        logic [2:0]  tc;
        logic [2:0]  attr;
    } cpl_rec_t;

    // AW and W travel together
    typedef struct packed {
        axil_addr_t addr;
        dw_t        data;
        strb_t      strb;
    } axil_wr_t;

endpackage

//--- hw/tlp_req_decode.sv
// TLP request decode stage
`timescale 1ns/10ps

module tlp_req_decode (
    input  logic                        clk,
    input  logic                        rst,
    input  pcie_axil_pkg::tlp_hdr_t     rx_req_hdr,
    input  pcie_axil_pkg::dw_t          rx_req_data,
    input  logic                        rx_req_valid,
    output logic                        rx_req_ready,
    output pcie_axil_pkg::axil_wr_t     m_axil_aw,
    output logic                        awvalid,
    input  logic                        awready,
    output logic                        wvalid,
    input  logic                        wready,
    output pcie_axil_pkg::axil_addr_t   araddr,
    output logic                        arvalid,
    input  logic                        arready,
    input  logic                        fifo_half_full,
    output logic                        push,
    output pcie_axil_pkg::cpl_rec_t     push_rec,
    output logic                        stat_err_cor,
    output logic                        stat_err_uncor
);

    pcie_axil_pkg::tlp_fmt_e    fmt;
    logic [4:0]                 tlp_type;
    logic [2:0]                 tc;
    logic [2:0]                 attr;
    logic [9:0]                 length;
    pcie_axil_pkg::req_id_t     req_id;
    pcie_axil_pkg::tag_t        tag;
    pcie_axil_pkg::strb_t       first_be;
    pcie_axil_pkg::axil_addr_t  addr;
    pcie_axil_pkg::byte_cnt_t   byte_count;
    pcie_axil_pkg::lower_addr_t lower_addr;
    logic                       accept;
    logic                       len_ok;
    logic                       link_idle;
    logic                       start_rd;
    logic                       start_wr;
    logic                       err_cor;
    logic                       err_uncor;

    assign fmt      = pcie_axil_pkg::tlp_fmt_e'(rx_req_hdr[127:125]);
    assign tlp_type = rx_req_hdr[124:120];
    assign tc       = rx_req_hdr[118:116];
    assign attr     = {rx_req_hdr[114], rx_req_hdr[109:108]};
    assign length   = rx_req_hdr[105:96];
    assign req_id   = rx_req_hdr[95:80];
    assign tag      = {rx_req_hdr[119], rx_req_hdr[115], rx_req_hdr[79:72]};  // T9, T8, tag
    assign first_be = rx_req_hdr[67:64];
    // 4DW header puts a 64-bit address in DW2 and DW3
    assign addr = fmt[0] ? {rx_req_hdr[63:2], 2'b00} : {32'd0, rx_req_hdr[63:34], 2'b00};

    assign accept    = rx_req_valid && rx_req_ready;
    assign len_ok    = length == 10'd1;
    assign link_idle = (!awvalid || awready) && (!wvalid || wready) && (!arvalid || arready);

    // span of enabled bytes, zero enables count as one
    always_comb begin
        casez (first_be)
            4'b1zz1:                   byte_count = 3'd4;
            4'b01z1, 4'b1z10:          byte_count = 3'd3;
            4'b0011, 4'b0110, 4'b1100: byte_count = 3'd2;
            default:                   byte_count = 3'd1;
        endcase
        casez (first_be)
            4'bzz10: lower_addr = {addr[6:2], 2'd1};
            4'bz100: lower_addr = {addr[6:2], 2'd2};
            4'b1000: lower_addr = {addr[6:2], 2'd3};
            default: lower_addr = {addr[6:2], 2'd0};
        endcase
    end

    always_comb begin
        push      = 1'b0;
        start_rd  = 1'b0;
        start_wr  = 1'b0;
        err_cor   = 1'b0;
        err_uncor = 1'b0;

        push_rec.op           = pcie_axil_pkg::OP_CPL;
        push_rec.status       = pcie_axil_pkg::CPL_SC;
        push_rec.byte_count   = '0;
        push_rec.lower_addr   = '0;
        push_rec.requester_id = req_id;
        push_rec.tag          = tag;
        push_rec.tc           = tc;
        push_rec.attr         = attr;

        if (!fmt[1] && tlp_type == 5'b00000) begin
            push = accept;  // memory read, always answered
            if (len_ok) begin
                start_rd            = accept;
                push_rec.op         = pcie_axil_pkg::OP_READ;
                push_rec.byte_count = byte_count;
                push_rec.lower_addr = lower_addr;
            end else begin
                err_cor         = 1'b1;
                push_rec.status = pcie_axil_pkg::CPL_CA;
            end
        end else if (fmt[1] && tlp_type == 5'b00000) begin
            if (len_ok) begin
                start_wr    = accept;
                push        = accept;  // keeps write order against later reads
                push_rec.op = pcie_axil_pkg::OP_WRITE;
            end else begin
                err_uncor = 1'b1;  // posted, nothing to answer
            end
        end else if (fmt[0] && tlp_type[4:3] == 2'b10) begin
            err_uncor = 1'b1;  // message
        end else if (tlp_type == 5'b01010 || tlp_type == 5'b01011) begin
            err_cor = 1'b1;  // unexpected completion
        end else begin
            err_cor         = 1'b1;
            push            = accept;
            push_rec.status = pcie_axil_pkg::CPL_UR;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_req_ready   <= 1'b0;
            awvalid        <= 1'b0;
            wvalid         <= 1'b0;
            arvalid        <= 1'b0;
            stat_err_cor   <= 1'b0;
            stat_err_uncor <= 1'b0;
        end else begin
            rx_req_ready   <= link_idle && !fifo_half_full && !start_rd && !start_wr;
            awvalid        <= (awvalid && !awready) || start_wr;
            wvalid         <= (wvalid && !wready) || start_wr;
            arvalid        <= (arvalid && !arready) || start_rd;
            stat_err_cor   <= accept && err_cor;
            stat_err_uncor <= accept && err_uncor;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            m_axil_aw.addr <= addr;
            m_axil_aw.data <= rx_req_data;
            m_axil_aw.strb <= first_be;
        end
    end

    assign araddr = m_axil_aw.addr;  // one address register for both channels

endmodule

//--- hw/cpl_order_fifo.sv
// completion ordering queue
`timescale 1ns/10ps

module cpl_order_fifo (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    push,
    input  pcie_axil_pkg::cpl_rec_t push_rec,
    input  logic                    pop,
    output pcie_axil_pkg::cpl_rec_t head,
    output logic                    head_valid,
    output logic                    half_full
);

    // extra msb is the wrap bit
    logic [pcie_axil_pkg::FIFO_ADDR_W:0] wr_ptr;
    logic [pcie_axil_pkg::FIFO_ADDR_W:0] rd_ptr;
    logic [pcie_axil_pkg::FIFO_ADDR_W:0] count;
    logic                                empty;
    logic                                load;

    pcie_axil_pkg::cpl_rec_t mem [2**pcie_axil_pkg::FIFO_ADDR_W];

    assign empty = wr_ptr == rd_ptr;
    assign count = wr_ptr - rd_ptr;
    // refill head when it is free or being consumed
    assign load  = !empty && (!head_valid || pop);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[pcie_axil_pkg::FIFO_ADDR_W-1:0]] <= push_rec;
        end
        if (load) begin
            head <= mem[rd_ptr[pcie_axil_pkg::FIFO_ADDR_W-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            head_valid <= 1'b0;
            half_full  <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (!head_valid || pop) begin
                head_valid <= !empty;
            end
            // at least half the depth in use
            half_full <= count[pcie_axil_pkg::FIFO_ADDR_W] || count[pcie_axil_pkg::FIFO_ADDR_W-1];
        end
    end

endmodule

//--- hw/cpl_gen.sv
// completion generator stage
`timescale 1ns/10ps

module cpl_gen (
    input  logic                    clk,
    input  logic                    rst,
    input  pcie_axil_pkg::cpl_rec_t head,
    input  logic                    head_valid,
    output logic                    pop,
    input  logic [7:0]              bus_num,
    input  logic                    bvalid,
    output logic                    bready,
    input  logic                    rvalid,
    input  pcie_axil_pkg::dw_t      rdata,
    output logic                    rready,
    output pcie_axil_pkg::tlp_hdr_t tx_cpl_hdr,
    output pcie_axil_pkg::dw_t      tx_cpl_data,
    output logic                    tx_cpl_valid,
    input  logic                    tx_cpl_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE,
        ST_CPL
    } state_e;

    state_e                  state;
    state_e                  state_next;
    logic                    bready_next;
    logic                    rready_next;
    logic                    cpl_free;
    logic                    is_read;
    logic                    tx_load;
    pcie_axil_pkg::dw_t      tx_load_data;
    pcie_axil_pkg::tlp_hdr_t cpl_hdr;

    assign cpl_free = !tx_cpl_valid || tx_cpl_ready;  // empty or draining
    assign is_read  = head.op == pcie_axil_pkg::OP_READ;

    always_comb begin
        cpl_hdr            = '0;
        cpl_hdr[127:125]   = is_read ? pcie_axil_pkg::FMT_3DW_DATA : pcie_axil_pkg::FMT_3DW;
        cpl_hdr[124:120]   = 5'b01010;  // Cpl / CplD
        cpl_hdr[119]       = head.tag[9];
        cpl_hdr[118:116]   = head.tc;
        cpl_hdr[115]       = head.tag[8];
        cpl_hdr[114]       = head.attr[2];
        cpl_hdr[109:108]   = head.attr[1:0];
        cpl_hdr[105:96]    = is_read ? 10'd1 : 10'd0;
        cpl_hdr[95:88]     = bus_num;
        cpl_hdr[87:80]     = 8'd0;  // function 0
        cpl_hdr[79:77]     = head.status;
        cpl_hdr[75:64]     = {9'd0, head.byte_count};
        cpl_hdr[63:48]     = head.requester_id;
        cpl_hdr[47:40]     = head.tag[7:0];
        cpl_hdr[38:32]     = head.lower_addr;
    end

    always_comb begin
        state_next   = state;
        pop          = 1'b0;
        bready_next  = 1'b0;
        rready_next  = 1'b0;
        tx_load      = 1'b0;
        tx_load_data = '0;
        case (state)
            ST_IDLE: begin
                if (head_valid) begin
                    case (head.op)
                        pcie_axil_pkg::OP_READ: begin
                            rready_next = cpl_free;
                            state_next  = ST_READ;
                        end
                        pcie_axil_pkg::OP_WRITE: begin
                            bready_next = 1'b1;
                            state_next  = ST_WRITE;
                        end
                        default: state_next = ST_CPL;
                    endcase
                end
            end
            ST_READ: begin
                rready_next = cpl_free;
                if (rready && rvalid) begin
                    rready_next  = 1'b0;
                    tx_load      = 1'b1;
                    tx_load_data = rdata;
                    pop          = 1'b1;
                    state_next   = ST_IDLE;
                end
            end
            ST_WRITE: begin
                bready_next = 1'b1;
                if (bready && bvalid) begin
                    bready_next = 1'b0;
                    pop         = 1'b1;  // posted, no completion
                    state_next  = ST_IDLE;
                end
            end
            ST_CPL: begin
                if (cpl_free) begin
                    tx_load    = 1'b1;
                    pop        = 1'b1;
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= ST_IDLE;
            bready       <= 1'b0;
            rready       <= 1'b0;
            tx_cpl_valid <= 1'b0;
        end else begin
            state        <= state_next;
            bready       <= bready_next;
            rready       <= rready_next;
            tx_cpl_valid <= tx_load || (tx_cpl_valid && !tx_cpl_ready);
        end
    end

    always_ff @(posedge clk) begin
        if (tx_load) begin
            tx_cpl_hdr  <= cpl_hdr;
            tx_cpl_data <= tx_load_data;
        end
    end

endmodule

//--- hw/pcie_axil_bridge.sv
// PCIe request to AXI-Lite bridge
`timescale 1ns/10ps

module pcie_axil_bridge (
    input  logic                      clk,
    input  logic                      rst,
    input  pcie_axil_pkg::tlp_hdr_t   rx_req_hdr,
    input  pcie_axil_pkg::dw_t        rx_req_data,
    input  logic                      rx_req_valid,
    output logic                      rx_req_ready,
    output pcie_axil_pkg::tlp_hdr_t   tx_cpl_hdr,
    output pcie_axil_pkg::dw_t        tx_cpl_data,
    output logic                      tx_cpl_valid,
    input  logic                      tx_cpl_ready,
    output pcie_axil_pkg::axil_wr_t   m_axil_aw,
    output logic [2:0]                awprot,
    output logic                      awvalid,
    input  logic                      awready,
    output logic                      wvalid,
    input  logic                      wready,
    input  logic                      bvalid,
    output logic                      bready,
    output pcie_axil_pkg::axil_addr_t araddr,
    output logic [2:0]                arprot,
    output logic                      arvalid,
    input  logic                      arready,
    input  logic                      rvalid,
    input  pcie_axil_pkg::dw_t        rdata,
    output logic                      rready,
    input  logic [7:0]                bus_num,
    output logic                      stat_err_cor,
    output logic                      stat_err_uncor
);

    logic                    push;
    pcie_axil_pkg::cpl_rec_t push_rec;
    logic                    pop;
    pcie_axil_pkg::cpl_rec_t head;
    logic                    head_valid;
    logic                    half_full;

    assign awprot = pcie_axil_pkg::AXIL_PROT;
    assign arprot = pcie_axil_pkg::AXIL_PROT;

    tlp_req_decode u_decode (
        .clk            (clk),
        .rst            (rst),
        .rx_req_hdr     (rx_req_hdr),
        .rx_req_data    (rx_req_data),
        .rx_req_valid   (rx_req_valid),
        .rx_req_ready   (rx_req_ready),
        .m_axil_aw      (m_axil_aw),
        .awvalid        (awvalid),
        .awready        (awready),
        .wvalid         (wvalid),
        .wready         (wready),
        .araddr         (araddr),
        .arvalid        (arvalid),
        .arready        (arready),
        .fifo_half_full (half_full),
        .push           (push),
        .push_rec       (push_rec),
        .stat_err_cor   (stat_err_cor),
        .stat_err_uncor (stat_err_uncor)
    );

    cpl_order_fifo u_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_rec   (push_rec),
        .pop        (pop),
        .head       (head),
        .head_valid (head_valid),
        .half_full  (half_full)
    );

    cpl_gen u_cpl (
        .clk          (clk),
        .rst          (rst),
        .head         (head),
        .head_valid   (head_valid),
        .pop          (pop),
        .bus_num      (bus_num),
        .bvalid       (bvalid),
        .bready       (bready),
        .rvalid       (rvalid),
        .rdata        (rdata),
        .rready       (rready),
        .tx_cpl_hdr   (tx_cpl_hdr),
        .tx_cpl_data  (tx_cpl_data),
        .tx_cpl_valid (tx_cpl_valid),
        .tx_cpl_ready (tx_cpl_ready)
    );

endmodule

//--- verification/tb_pcie_axil_bridge.sv
// PCIe to AXI-Lite bridge testbench
`timescale 1ns/10ps

module tb_pcie_axil_bridge;

    localparam int N_REQ = 35;  // requests over all tests

    logic                      clk = 1'b0;
    logic                      rst;
    pcie_axil_pkg::tlp_hdr_t   rx_req_hdr;
    pcie_axil_pkg::dw_t        rx_req_data;
    logic                      rx_req_valid;
    logic                      rx_req_ready;
    pcie_axil_pkg::tlp_hdr_t   tx_cpl_hdr;
    pcie_axil_pkg::dw_t        tx_cpl_data;
    logic                      tx_cpl_valid;
    logic                      tx_cpl_ready = 1'b0;
    pcie_axil_pkg::axil_wr_t   m_axil_aw;
    logic [2:0]                awprot;
    logic                      awvalid;
    logic                      awready = 1'b0;
    logic                      wvalid;
    logic                      wready = 1'b0;
    logic                      bvalid = 1'b0;
    logic                      bready;
    pcie_axil_pkg::axil_addr_t araddr;
    logic [2:0]                arprot;
    logic                      arvalid;
    logic                      arready = 1'b0;
    logic                      rvalid = 1'b0;
    pcie_axil_pkg::dw_t        rdata = '0;
    logic                      rready;
    logic [7:0]                bus_num;
    logic                      stat_err_cor;
    logic                      stat_err_uncor;

    pcie_axil_pkg::dw_t mem [256];      // AXI-Lite memory model
    pcie_axil_pkg::dw_t exp_mem [256];  // expected contents
    pcie_axil_pkg::dw_t r_q [$];
    logic               aw_seen = 1'b0;
    logic               w_seen = 1'b0;
    int                 b_pending = 0;
    int                 b_done = 0;
    int                 aw_count = 0;
    int                 ar_count = 0;
    logic               cpl_rand = 1'b0;
    logic [31:0]        bus_rng = 32'd70664;
    logic [31:0]        stim_rng = 32'd70664 ^ 32'h9e37_79b9;  // second stream

    pcie_axil_pkg::tlp_hdr_t   cpl_hdr_q [$];
    pcie_axil_pkg::dw_t        cpl_data_q [$];
    pcie_axil_pkg::tag_t       exp_tag_q [$];
    pcie_axil_pkg::axil_addr_t exp_addr_q [$];
    pcie_axil_pkg::strb_t      exp_be_q [$];
    pcie_axil_pkg::dw_t        exp_data_q [$];
    pcie_axil_pkg::axil_addr_t aw_addr_q [$];
    pcie_axil_pkg::axil_addr_t ar_addr_q [$];

    int                  cor_count = 0;
    int                  uncor_count = 0;
    int                  errors = 0;
    int                  checks = 0;
    int                  n_sent = 0;
    pcie_axil_pkg::tag_t tag_ctr = 10'h2fc;  // crosses T8/T9
    string               test_name = "reset";

    pcie_axil_bridge UUT (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic pcie_axil_pkg::dw_t fill_word(input int idx);
        return (idx * 32'h0100_0193) ^ 32'h5a5a_0000;
    endfunction

    function automatic int lowest_be(input pcie_axil_pkg::strb_t be);
        for (int k = 0; k < 4; k++) begin
            if (be[k]) begin
                return k;
            end
        end
        return -1;
    endfunction

    function automatic int exp_byte_count(input pcie_axil_pkg::strb_t be);
        int hi;
        hi = -1;
        for (int k = 0; k < 4; k++) begin
            if (be[k]) begin
                hi = k;
            end
        end
        return (hi < 0) ? 1 : hi - lowest_be(be) + 1;
    endfunction

    function automatic logic [6:0] exp_lower_addr(input pcie_axil_pkg::axil_addr_t addr,
                                                  input pcie_axil_pkg::strb_t be);
        int lo;
        lo = lowest_be(be);
        return {addr[6:2], (lo < 0) ? 2'd0 : lo[1:0]};
    endfunction

    // tc, attr and requester id all follow from the tag
    function automatic pcie_axil_pkg::tlp_hdr_t make_hdr(input logic [2:0] fmt,
            input logic [4:0] typ, input logic [9:0] len, input pcie_axil_pkg::axil_addr_t addr,
            input pcie_axil_pkg::strb_t be, input pcie_axil_pkg::tag_t tag);
        pcie_axil_pkg::tlp_hdr_t h;
        h = '0;
        h[127:125] = fmt;
        h[124:120] = typ;
        h[119]     = tag[9];
        h[118:116] = tag[2:0];
        h[115]     = tag[8];
        h[114]     = tag[5];
        h[109:108] = tag[4:3];
        h[105:96]  = len;
        h[95:80]   = {6'h2a, tag};
        h[79:72]   = tag[7:0];
        h[67:64]   = be;
        if (fmt[0]) begin
            h[63:0] = {addr[63:2], 2'b00};
        end else begin
            h[63:34] = addr[31:2];
        end
        return h;
    endfunction

    // AXI-Lite slave and completion sink with random ready
    always @(posedge clk) begin : bus_model
        if (rst) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] = fill_word(i);
            end
        end else begin
            bus_rng = next_rand(bus_rng);
            awready      <= bus_rng[0];
            wready       <= bus_rng[1];
            arready      <= bus_rng[2];
            tx_cpl_ready <= cpl_rand ? bus_rng[3] : 1'b1;
            if (awvalid && awready) begin
                aw_seen = 1'b1;
                aw_count++;
                compare("awprot", 3'b010, awprot);
                if (aw_addr_q.size() == 0) begin
                    errors++;
                    $display("AW handshake in %s with no write outstanding", test_name);
                end else begin
                    compare("awaddr", aw_addr_q.pop_front(), m_axil_aw.addr);
                end
            end
            if (wvalid && wready) begin
                w_seen = 1'b1;
            end
            if (aw_seen && w_seen) begin
                for (int k = 0; k < 4; k++) begin
                    if (m_axil_aw.strb[k]) begin
                        mem[m_axil_aw.addr[9:2]][8*k +: 8] = m_axil_aw.data[8*k +: 8];
                    end
                end
                aw_seen = 1'b0;
                w_seen  = 1'b0;
                b_pending++;
            end
            if (bvalid && bready) begin
                b_pending--;
                b_done++;
            end
            if (arvalid && arready) begin
                r_q.push_back(mem[araddr[9:2]]);
                ar_count++;
                compare("arprot", 3'b010, arprot);
                if (ar_addr_q.size() == 0) begin
                    errors++;
                    $display("AR handshake in %s with no read outstanding", test_name);
                end else begin
                    compare("araddr", ar_addr_q.pop_front(), araddr);
                end
            end
            if (rvalid && rready) begin
                void'(r_q.pop_front());
            end
            bvalid <= b_pending != 0;
            rvalid <= r_q.size() != 0;
            rdata  <= (r_q.size() != 0) ? r_q[0] : '0;
        end
    end

    always @(posedge clk) begin
        if (tx_cpl_valid && tx_cpl_ready) begin
            cpl_hdr_q.push_back(tx_cpl_hdr);
            cpl_data_q.push_back(tx_cpl_data);
        end
        if (stat_err_cor) cor_count++;
        if (stat_err_uncor) uncor_count++;
    end

    task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("** Error %s: %s expected %0h, actual %0h", test_name, what, exp, act);
        end
    endtask

    task automatic send_req(input pcie_axil_pkg::tlp_hdr_t hdr, input pcie_axil_pkg::dw_t data);
        @(posedge clk);
        rx_req_hdr   <= hdr;
        rx_req_data  <= data;
        rx_req_valid <= 1'b1;
        @(posedge clk);
        while (!rx_req_ready) @(posedge clk);
        rx_req_valid <= 1'b0;
        n_sent++;
    endtask

    task automatic do_write(input pcie_axil_pkg::axil_addr_t addr,
                            input pcie_axil_pkg::dw_t data, input pcie_axil_pkg::strb_t be);
        pcie_axil_pkg::tag_t t;
        logic [2:0]          fmt;
        t = tag_ctr;
        tag_ctr++;
        fmt = (addr[63:32] != 0) ? pcie_axil_pkg::FMT_4DW_DATA : pcie_axil_pkg::FMT_3DW_DATA;
        aw_addr_q.push_back(addr);
        send_req(make_hdr(fmt, 5'b00000, 10'd1, addr, be, t), data);
        for (int k = 0; k < 4; k++) begin
            if (be[k]) exp_mem[addr[9:2]][8*k +: 8] = data[8*k +: 8];
        end
    endtask

    task automatic do_read(input pcie_axil_pkg::axil_addr_t addr,
                           input pcie_axil_pkg::strb_t be);
        pcie_axil_pkg::tag_t t;
        logic [2:0]          fmt;
        t = tag_ctr;
        tag_ctr++;
        fmt = (addr[63:32] != 0) ? pcie_axil_pkg::FMT_4DW : pcie_axil_pkg::FMT_3DW;
        ar_addr_q.push_back(addr);
        send_req(make_hdr(fmt, 5'b00000, 10'd1, addr, be, t), '0);
        exp_tag_q.push_back(t);
        exp_addr_q.push_back(addr);
        exp_be_q.push_back(be);
        exp_data_q.push_back(exp_mem[addr[9:2]]);
    endtask

    task automatic check_cpl(input logic [2:0] fmt, input logic [2:0] status,
            input pcie_axil_pkg::tag_t tag, input pcie_axil_pkg::strb_t be,
            input pcie_axil_pkg::axil_addr_t addr, input pcie_axil_pkg::dw_t data);
        pcie_axil_pkg::tlp_hdr_t h;
        pcie_axil_pkg::dw_t      d;
        while (cpl_hdr_q.size() == 0) @(posedge clk);
        h = cpl_hdr_q.pop_front();
        d = cpl_data_q.pop_front();
        compare("fmt", fmt, h[127:125]);
        compare("type", 5'b01010, h[124:120]);
        compare("length", (fmt == pcie_axil_pkg::FMT_3DW_DATA) ? 1 : 0, h[105:96]);
        compare("status", status, h[79:77]);
        compare("completer id", {bus_num, 8'h00}, h[95:80]);
        compare("requester id", {6'h2a, tag}, h[63:48]);
        compare("tag", tag, {h[119], h[115], h[47:40]});
        compare("tc", tag[2:0], h[118:116]);
        compare("attr", tag[5:3], {h[114], h[109:108]});
        compare("data", data, d);
        if (fmt == pcie_axil_pkg::FMT_3DW_DATA) begin
            compare("byte count", exp_byte_count(be), h[75:64]);
            compare("lower addr", exp_lower_addr(addr, be), h[38:32]);
        end
    endtask

    task automatic check_next_read();
        pcie_axil_pkg::tag_t       t;
        pcie_axil_pkg::axil_addr_t a;
        pcie_axil_pkg::strb_t      be;
        pcie_axil_pkg::dw_t        d;
        t  = exp_tag_q.pop_front();
        a  = exp_addr_q.pop_front();
        be = exp_be_q.pop_front();
        d  = exp_data_q.pop_front();
        check_cpl(pcie_axil_pkg::FMT_3DW_DATA, pcie_axil_pkg::CPL_SC, t, be, a, d);
    endtask

    task automatic write_read_pairs();
        pcie_axil_pkg::axil_addr_t addr;
        pcie_axil_pkg::strb_t      wbe;
        test_name = "write_read";
        for (int i = 0; i < 4; i++) begin
            stim_rng = next_rand(stim_rng);
            addr = (i == 3) ? 64'h0000_0001_0000_0f40 : 64'h100 + 64'(i) * 64'h1c4;
            wbe  = (i == 0) ? 4'b1111 : stim_rng[7:4];
            do_write(addr, stim_rng, wbe);
            do_read(addr, stim_rng[11:8]);
            check_next_read();  // a write completion would show up here first
        end
    endtask

    task automatic bad_read_length();
        int                  cor0;
        int                  ar0;
        pcie_axil_pkg::tag_t t;
        test_name = "bad_read_length";
        cor0 = cor_count;
        ar0  = ar_count;
        t    = tag_ctr;
        tag_ctr++;
        send_req(make_hdr(pcie_axil_pkg::FMT_3DW, 5'b00000, 10'd2, 64'h80, 4'hf, t), '0);
        check_cpl(pcie_axil_pkg::FMT_3DW, pcie_axil_pkg::CPL_CA, t, '0, '0, '0);
        compare("cor pulses", cor0 + 1, cor_count);
        compare("ar handshakes", ar0, ar_count);
    endtask

    task automatic dropped_requests();
        int                  uncor0;
        int                  aw0;
        pcie_axil_pkg::tag_t t;
        test_name = "dropped";
        uncor0 = uncor_count;
        aw0    = aw_count;
        t      = tag_ctr;
        tag_ctr++;
        send_req(make_hdr(pcie_axil_pkg::FMT_3DW_DATA, 5'b00000, 10'd3, 64'h40, 4'hf, t),
                 32'hdead_beef);
        while (uncor_count == uncor0) @(posedge clk);
        t = tag_ctr;
        tag_ctr++;
        send_req(make_hdr(pcie_axil_pkg::FMT_4DW, 5'b10100, 10'd0, '0, '0, t), '0);  // message
        while (uncor_count == uncor0 + 1) @(posedge clk);
        do_read(64'h40, 4'hf);  // memory untouched and nothing queued ahead
        check_next_read();
        compare("uncor pulses", uncor0 + 2, uncor_count);
        compare("aw handshakes", aw0, aw_count);
    endtask

    task automatic unsupported_requests();
        int                  cor0;
        pcie_axil_pkg::tag_t t;
        test_name = "unsupported";
        cor0 = cor_count;
        t    = tag_ctr;
        tag_ctr++;
        send_req(make_hdr(pcie_axil_pkg::FMT_3DW, 5'b00010, 10'd1, 64'h20, 4'hf, t), '0);
        check_cpl(pcie_axil_pkg::FMT_3DW, pcie_axil_pkg::CPL_UR, t, '0, '0, '0);
        compare("cor pulses after io read", cor0 + 1, cor_count);
        t = tag_ctr;
        tag_ctr++;
        send_req(make_hdr(pcie_axil_pkg::FMT_3DW_DATA, 5'b01010, 10'd1, '0, '0, t), 32'h1234);
        while (cor_count == cor0 + 1) @(posedge clk);
        do_read(64'h24, 4'b0110);
        check_next_read();
        compare("cor pulses", cor0 + 2, cor_count);
    endtask

    task automatic random_burst();
        int                        n_wr;
        int                        b0;
        logic [31:0]               r;
        pcie_axil_pkg::axil_addr_t addr;
        test_name = "burst";
        cpl_rand  <= 1'b1;
        n_wr      = 0;
        b0        = b_done;
        for (int i = 0; i < 20; i++) begin
            stim_rng = next_rand(stim_rng);
            r    = stim_rng;
            addr = 64'h800 + {r[7:4], 2'b00};  // small window for many overlaps
            if (r[0]) begin
                do_write(addr, next_rand(r), r[11:8]);
                n_wr++;
            end else begin
                do_read(addr, r[11:8]);
            end
        end
        while (exp_tag_q.size() != 0) check_next_read();
        while (b_done < b0 + n_wr) @(posedge clk);
        compare("b responses", b0 + n_wr, b_done);
        cpl_rand <= 1'b0;
    endtask

    initial begin
        rst          = 1'b1;
        rx_req_hdr   = '0;
        rx_req_data  = '0;
        rx_req_valid = 1'b0;
        bus_num      = 8'h3c;
        for (int i = 0; i < 256; i++) begin
            exp_mem[i] = fill_word(i);
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        write_read_pairs();
        bad_read_length();
        dropped_requests();
        unsupported_requests();
        random_burst();
        test_name = "end";
        compare("leftover completions", 0, cpl_hdr_q.size());
        $display("%0d errors in %0d checks, %0d requests sent", errors, checks, n_sent);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (N_REQ * 200 + 500) @(posedge clk);
        $display("timeout in %s after %0d requests sent", test_name, n_sent);
        $display("Test failed");
        $finish;
    end

endmodule

//--- sources.f
hw/pcie_axil_pkg.sv
hw/tlp_req_decode.sv
hw/cpl_order_fifo.sv
hw/cpl_gen.sv
hw/pcie_axil_bridge.sv
verification/tb_pcie_axil_bridge.sv

//--- run.sh
#!/bin/sh
# build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_pcie_axil_bridge \
    -f sources.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
